// ==== rtl/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// ---------------------------------------------------------------------------
// cache geometry
// ---------------------------------------------------------------------------

// byte address width of the fetch side and the bus
`define ICACHE_ADDR_BITS 32

// index bits, 16 lines
`define ICACHE_INDEX_BITS 4

// byte offset bits within a line, 16 byte lines
`define ICACHE_OFFSET_BITS 4

// words per line, 32 bit words
`define ICACHE_LINE_WORDS (1 << (`ICACHE_OFFSET_BITS - 2))

`endif

// ==== rtl/icache_pkg.sv ====
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

    // derived field widths
    localparam int TAG_BITS      = `ICACHE_ADDR_BITS - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS;
    localparam int WORD_SEL_BITS = `ICACHE_OFFSET_BITS - 2;  // drop byte lanes

    typedef logic [`ICACHE_ADDR_BITS-1:0]  addr_t;      // byte address
    typedef logic [31:0]                   word_t;      // instruction word
    typedef logic [TAG_BITS-1:0]           tag_t;       // bits above index
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;     // line number
    typedef logic [WORD_SEL_BITS-1:0]      word_sel_t;  // word within line
    typedef logic [31:0]                   count_t;     // event counter

    // lookup stage
    typedef enum logic [1:0] {
        LOOK_IDLE,   // waiting for a request
        LOOK_MISS,   // refill running
        LOOK_REPLY   // response cycle, request ignored
    } lookup_state_t;

    // refill stage
    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_BUS,   // cyc held, one stb per word
        REFILL_LAST   // bus released
    } refill_state_t;

endpackage

`default_nettype wire

// ==== rtl/icache_lookup.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_lookup (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  flush,

    // fetch side
    input  wire logic                  req_valid,
    input  wire icache_pkg::addr_t     req_addr,
    output logic                       resp_valid,
    output icache_pkg::word_t          resp_data,

    // statistics
    output icache_pkg::count_t         hit_count,
    output icache_pkg::count_t         miss_count,

    // to refill stage
    output logic                       miss_start,
    output icache_pkg::addr_t          miss_addr,

    // from refill stage
    input  wire logic                  fill_we,
    input  wire icache_pkg::word_sel_t fill_word,
    input  wire icache_pkg::word_t     fill_data,
    input  wire logic                  fill_done
);

    localparam int LINES = 1 << `ICACHE_INDEX_BITS;
    localparam int WORDS = LINES * `ICACHE_LINE_WORDS;

    localparam int TAG_LO   = `ICACHE_INDEX_BITS + `ICACHE_OFFSET_BITS;
    localparam int INDEX_LO = `ICACHE_OFFSET_BITS;

    // ------------------------------------------------------------------------
    // address split
    // ------------------------------------------------------------------------

    icache_pkg::tag_t      req_tag;
    icache_pkg::index_t    req_index;
    icache_pkg::word_sel_t req_sel;

    icache_pkg::addr_t     held_addr;  // request that missed
    icache_pkg::tag_t      held_tag;
    icache_pkg::index_t    held_index;
    icache_pkg::word_sel_t held_sel;

    assign req_tag   = req_addr[`ICACHE_ADDR_BITS-1:TAG_LO];
    assign req_index = req_addr[TAG_LO-1:INDEX_LO];
    assign req_sel   = req_addr[INDEX_LO-1:2];  // bits 1:0 ignored

    assign held_tag   = held_addr[`ICACHE_ADDR_BITS-1:TAG_LO];
    assign held_index = held_addr[TAG_LO-1:INDEX_LO];
    assign held_sel   = held_addr[INDEX_LO-1:2];

    // line base for the refill, stable for the whole miss
    assign miss_addr = {held_addr[`ICACHE_ADDR_BITS-1:INDEX_LO], {INDEX_LO{1'b0}}};

    // ------------------------------------------------------------------------
    // arrays and hit test
    // ------------------------------------------------------------------------

    icache_pkg::tag_t  tag_mem [LINES];
    icache_pkg::word_t data_mem [WORDS];   // indexed {line, word}
    logic [LINES-1:0]  line_valid;

    icache_pkg::lookup_state_t state;

    logic hit;
    logic take_req;  // request accepted this cycle
    logic filling;

    assign hit      = line_valid[req_index] && (tag_mem[req_index] == req_tag);
    assign take_req = (state == icache_pkg::LOOK_IDLE) && req_valid;
    assign filling  = (state == icache_pkg::LOOK_MISS);

    // valid bits, flush wipes all of them at once
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            line_valid <= '0;
        end else if (filling && fill_done) begin
            line_valid[held_index] <= 1'b1;
        end
    end

    // tag and data writes during refill
    always_ff @(posedge clock) begin
        if (filling && fill_we) begin
            data_mem[{held_index, fill_word}] <= fill_data;
        end
        if (filling && fill_done) begin
            tag_mem[held_index] <= held_tag;  // line complete with this word
        end
    end

    // ------------------------------------------------------------------------
    // control FSM and counters
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= icache_pkg::LOOK_IDLE;
            resp_valid <= 1'b0;
            miss_start <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            resp_valid <= 1'b0;  // pulses by default
            miss_start <= 1'b0;
            case (state)
                icache_pkg::LOOK_IDLE: begin
                    if (req_valid && hit) begin
                        resp_valid <= 1'b1;
                        hit_count  <= hit_count + 1'b1;
                        state      <= icache_pkg::LOOK_REPLY;
                    end else if (req_valid) begin
                        miss_start <= 1'b1;           // refill starts next cycle
                        miss_count <= miss_count + 1'b1;
                        state      <= icache_pkg::LOOK_MISS;
                    end
                end
                icache_pkg::LOOK_MISS: begin
                    if (fill_done) begin
                        resp_valid <= 1'b1;
                        state      <= icache_pkg::LOOK_REPLY;
                    end
                end
                icache_pkg::LOOK_REPLY: begin
                    state <= icache_pkg::LOOK_IDLE;   // requester still holds req here
                end
                default: begin
                    state <= icache_pkg::LOOK_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // payload registers
    // ------------------------------------------------------------------------

    // held request, latched only on a miss
    always_ff @(posedge clock) begin
        if (take_req && !hit) begin
            held_addr <= req_addr;
        end
    end

    // response word
    always_ff @(posedge clock) begin
        if (take_req && hit) begin
            resp_data <= data_mem[{req_index, req_sel}];
        end else if (filling && fill_we && (fill_word == held_sel)) begin
            // requested word taken as it streams past
            resp_data <= fill_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icache_refill.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_refill (
    input  wire logic              clock,
    input  wire logic              reset,

    // from lookup stage
    input  wire logic              miss_start,
    input  wire icache_pkg::addr_t miss_addr,   // line base

    // wishbone classic read master
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output icache_pkg::addr_t      wb_adr,
    input  wire logic              wb_ack,
    input  wire icache_pkg::word_t wb_rdata,

    // word stream to lookup stage
    output logic                   fill_we,
    output icache_pkg::word_sel_t  fill_word,
    output icache_pkg::word_t      fill_data,
    output logic                   fill_done
);

    icache_pkg::refill_state_t state;

    icache_pkg::word_sel_t beat;   // word number of the current bus address
    logic                  last_beat;

    // base is line aligned, so the word bits of the address count the beats
    assign beat      = wb_adr[`ICACHE_OFFSET_BITS-1:2];
    assign last_beat = (beat == icache_pkg::word_sel_t'(`ICACHE_LINE_WORDS - 1));

    // ------------------------------------------------------------------------
    // bus FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= icache_pkg::REFILL_IDLE;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            fill_we   <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_we   <= 1'b0;
            fill_done <= 1'b0;
            case (state)
                icache_pkg::REFILL_IDLE: begin
                    if (miss_start) begin
                        wb_cyc <= 1'b1;  // cyc and stb rise with the base address
                        wb_stb <= 1'b1;
                        state  <= icache_pkg::REFILL_BUS;
                    end
                end
                icache_pkg::REFILL_BUS: begin
                    if (wb_ack) begin
                        fill_we <= 1'b1;
                        if (last_beat) begin
                            fill_done <= 1'b1;     // same cycle as last fill_we
                            wb_cyc    <= 1'b0;
                            wb_stb    <= 1'b0;
                            state     <= icache_pkg::REFILL_LAST;
                        end
                    end
                end
                icache_pkg::REFILL_LAST: begin
                    // bus already released, one spare cycle
                    state <= icache_pkg::REFILL_IDLE;
                end
                default: begin
                    state <= icache_pkg::REFILL_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // address and data path
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (state == icache_pkg::REFILL_IDLE && miss_start) begin
            wb_adr <= miss_addr;
        end else if (state == icache_pkg::REFILL_BUS && wb_ack && !last_beat) begin
            wb_adr <= wb_adr + icache_pkg::addr_t'(4);  // next word, stb stays up
        end
    end

    // data and word number for the lookup stage, one cycle after ack
    always_ff @(posedge clock) begin
        if (state == icache_pkg::REFILL_BUS && wb_ack) begin
            fill_word <= beat;
            fill_data <= wb_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
`default_nettype none

module icache_top (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               flush,

    // fetch side
    input  wire logic               req_valid,
    input  wire icache_pkg::addr_t  req_addr,
    output wire logic               resp_valid,
    output wire icache_pkg::word_t  resp_data,

    // statistics
    output wire icache_pkg::count_t hit_count,
    output wire icache_pkg::count_t miss_count,

    // wishbone classic, read only
    output wire logic               wb_cyc,
    output wire logic               wb_stb,
    output wire icache_pkg::addr_t  wb_adr,
    input  wire logic               wb_ack,
    input  wire icache_pkg::word_t  wb_rdata
);

    // ------------------------------------------------------------------------
    // stage to stage
    // ------------------------------------------------------------------------

    wire logic                  miss_start;
    wire icache_pkg::addr_t     miss_addr;   // line base of the missing line

    wire logic                  fill_we;
    wire icache_pkg::word_sel_t fill_word;
    wire icache_pkg::word_t     fill_data;
    wire logic                  fill_done;

    // lookup, tag and data arrays
    icache_lookup i_icache_lookup (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .hit_count  (hit_count),
        .miss_count (miss_count),
        .miss_start (miss_start),
        .miss_addr  (miss_addr),
        .fill_we    (fill_we),
        .fill_word  (fill_word),
        .fill_data  (fill_data),
        .fill_done  (fill_done)
    );

    // refill, bus master
    icache_refill i_icache_refill (
        .clock      (clock),
        .reset      (reset),
        .miss_start (miss_start),
        .miss_addr  (miss_addr),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_ack     (wb_ack),
        .wb_rdata   (wb_rdata),
        .fill_we    (fill_we),
        .fill_word  (fill_word),
        .fill_data  (fill_data),
        .fill_done  (fill_done)
    );

endmodule

`default_nettype wire

// ==== tb/wb_mem_model.sv ====
`default_nettype none

module wb_mem_model (
    input  wire logic              clock,
    input  wire logic              reset,

    // wishbone classic slave, read only
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire icache_pkg::addr_t wb_adr,
    output logic                   wb_ack,
    output icache_pkg::word_t      wb_rdata
);

    localparam int MEM_WORDS = 4096;  // 16 KB window from address zero

    icache_pkg::word_t mem [MEM_WORDS];
    logic [1:0]        wait_left;     // wait states before the next ack

    function automatic int unsigned word_index(input icache_pkg::addr_t addr);
        return (addr >> 2) % MEM_WORDS;
    endfunction

    // used by the reference model
    function automatic icache_pkg::word_t get_word(input icache_pkg::addr_t addr);
        return mem[word_index(addr)];
    endfunction

    task automatic set_word(input icache_pkg::addr_t addr, input icache_pkg::word_t data);
        mem[word_index(addr)] = data;
    endtask

    // every word starts as its own byte address xor a marker
    initial begin
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = icache_pkg::word_t'(i * 4) ^ 32'h5a5a0000;
        end
    end

    // ------------------------------------------------------------------------
    // ack with 0 to 3 wait states
    // ------------------------------------------------------------------------

    always @(posedge clock) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            wait_left <= 2'($urandom % 4);
        end else begin
            wb_ack <= 1'b0;                            // one cycle pulse
            if (wb_cyc && wb_stb && !wb_ack) begin     // no new beat in the ack cycle
                if (wait_left == 2'd0) begin
                    wb_ack    <= 1'b1;
                    wb_rdata  <= mem[word_index(wb_adr)];
                    wait_left <= 2'($urandom % 4);     // drawn for the next beat
                end else begin
                    wait_left <= wait_left - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/icache_tb.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_RANDOM     = 300;
    localparam int NUM_REQUESTS   = 11 + NUM_RANDOM;  // directed plus random
    localparam int CYCLES_PER_REQ = 40;               // four slow beats plus margin
    localparam int LINES          = 1 << `ICACHE_INDEX_BITS;
    localparam int LINE_WORDS     = `ICACHE_LINE_WORDS;
    localparam int INDEX_LO       = `ICACHE_OFFSET_BITS;
    localparam int TAG_LO         = `ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS;

    logic               clock;
    logic               reset;
    logic               flush;
    logic               req_valid;
    icache_pkg::addr_t  req_addr;
    logic               resp_valid;
    icache_pkg::word_t  resp_data;
    icache_pkg::count_t hit_count;
    icache_pkg::count_t miss_count;
    logic               wb_cyc;
    logic               wb_stb;
    icache_pkg::addr_t  wb_adr;
    logic               wb_ack;
    icache_pkg::word_t  wb_rdata;

    // reference model state
    icache_pkg::tag_t   shadow_tag   [LINES];
    logic               shadow_valid [LINES];
    icache_pkg::word_t  shadow_data  [LINES][LINE_WORDS];
    icache_pkg::word_t  exp_data;
    logic               expect_hit;
    icache_pkg::count_t exp_hits;
    icache_pkg::count_t exp_misses;

    string              test_name;
    int                 error_count;
    int                 beat_no;      // acks seen in the current bus cycle
    icache_pkg::addr_t  exp_adr;

    icache_top i_icache_top (
        .clock(clock), .reset(reset), .flush(flush),
        .req_valid(req_valid), .req_addr(req_addr),
        .resp_valid(resp_valid), .resp_data(resp_data),
        .hit_count(hit_count), .miss_count(miss_count),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_ack(wb_ack), .wb_rdata(wb_rdata)
    );

    wb_mem_model i_wb_mem_model (
        .clock(clock), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_ack(wb_ack), .wb_rdata(wb_rdata)
    );

    always #5 clock = ~clock;

    function automatic icache_pkg::addr_t line_base(input icache_pkg::addr_t a);
        return a & ~icache_pkg::addr_t'((1 << INDEX_LO) - 1);
    endfunction

    // four tags by four lines by four words, 64 words
    function automatic icache_pkg::addr_t random_addr();
        icache_pkg::addr_t a;
        a      = '0;
        a[9:8] = 2'($urandom % 4);
        a[5:4] = 2'($urandom % 4);
        a[3:2] = 2'($urandom % 4);
        return a;
    endfunction

    // ------------------------------------------------------------------------
    // reference model and stimulus
    // ------------------------------------------------------------------------

    task automatic predict(input icache_pkg::addr_t addr);
        icache_pkg::tag_t      tag;
        icache_pkg::index_t    idx;
        icache_pkg::word_sel_t sel;
        int                    w;
        tag        = addr[`ICACHE_ADDR_BITS-1:TAG_LO];
        idx        = addr[TAG_LO-1:INDEX_LO];
        sel        = addr[INDEX_LO-1:2];
        expect_hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
        if (expect_hit) begin
            exp_hits = exp_hits + 1;
        end else begin
            for (w = 0; w < LINE_WORDS; w++) begin  // line as the memory holds it now
                shadow_data[idx][w] = i_wb_mem_model.get_word(line_base(addr) + 4 * w);
            end
            shadow_tag[idx]   = tag;
            shadow_valid[idx] = 1'b1;
            exp_misses        = exp_misses + 1;
        end
        exp_data = shadow_data[idx][sel];
    endtask

    task automatic issue_request(input icache_pkg::addr_t addr);
        @(posedge clock);
        #1;
        predict(addr);
        req_addr  = addr;
        req_valid = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (!resp_valid);
        @(posedge clock);  // drop in the cycle after the response
        #1;
        req_valid = 1'b0;
    endtask

    task automatic pulse_flush();
        int i;
        @(posedge clock);
        #1;
        flush = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
        for (i = 0; i < LINES; i++) begin
            shadow_valid[i] = 1'b0;
        end
    endtask

    // bus beat tracker, expected address from line base and beat number
    always @(posedge clock) begin
        if (reset || !wb_cyc) begin
            beat_no <= 0;
        end else if (wb_ack) begin
            beat_no <= beat_no + 1;
        end
    end

    assign exp_adr = line_base(req_addr) + icache_pkg::addr_t'(4 * beat_no);

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    a_reset_idle: assert property (@(posedge clock)
        reset |=> !resp_valid && !wb_cyc && !wb_stb)
    else begin
        error_count = error_count + 1;
        $display("response or bus cycle active right after a reset edge");
    end

    a_reset_counts: assert property (@(posedge clock)
        reset |=> hit_count == 0 && miss_count == 0)
    else begin
        error_count = error_count + 1;
        $display("Fail %s: counters expected 0/0 actual %0d/%0d", test_name,
                 $sampled(hit_count), $sampled(miss_count));
    end

    a_resp_data: assert property (@(posedge clock) disable iff (reset)
        resp_valid |-> resp_data == exp_data)
    else begin
        error_count = error_count + 1;
        $display("Fail %s: read data expected %h actual %h", test_name,
                 $sampled(exp_data), $sampled(resp_data));
    end

    a_hit_count: assert property (@(posedge clock) disable iff (reset)
        resp_valid |-> hit_count == exp_hits)
    else begin
        error_count = error_count + 1;
        $display("Fail %s: hit_count expected %0d actual %0d", test_name,
                 $sampled(exp_hits), $sampled(hit_count));
    end

    a_miss_count: assert property (@(posedge clock) disable iff (reset)
        resp_valid |-> miss_count == exp_misses)
    else begin
        error_count = error_count + 1;
        $display("Fail %s: miss_count expected %0d actual %0d", test_name,
                 $sampled(exp_misses), $sampled(miss_count));
    end

    a_resp_pulse: assert property (@(posedge clock) disable iff (reset)
        resp_valid |=> !resp_valid)
    else begin
        error_count = error_count + 1;
        $display("%s: resp_valid held longer than one cycle", test_name);
    end

    a_resp_pending: assert property (@(posedge clock) disable iff (reset)
        resp_valid |-> req_valid)
    else begin
        error_count = error_count + 1;
        $display("%s: response given with no request pending", test_name);
    end

    a_hit_latency: assert property (@(posedge clock) disable iff (reset)
        $rose(req_valid) && expect_hit |=> resp_valid)
    else begin
        error_count = error_count + 1;
        $display("%s: hit not answered in the cycle after the request", test_name);
    end

    a_miss_latency: assert property (@(posedge clock) disable iff (reset)
        $rose(req_valid) && !expect_hit |=> !resp_valid)
    else begin
        error_count = error_count + 1;
        $display("%s: miss answered without a refill", test_name);
    end

    a_bus_on_miss: assert property (@(posedge clock) disable iff (reset)
        wb_cyc |-> req_valid && !expect_hit)
    else begin
        error_count = error_count + 1;
        $display("%s: bus cycle while no miss was pending", test_name);
    end

    a_cyc_stb: assert property (@(posedge clock) disable iff (reset)
        wb_cyc == wb_stb)
    else begin
        error_count = error_count + 1;
        $display("%s: wb_cyc and wb_stb disagree", test_name);
    end

    a_bus_addr: assert property (@(posedge clock) disable iff (reset)
        wb_cyc |-> wb_adr == exp_adr)
    else begin
        error_count = error_count + 1;
        $display("Fail %s: bus address expected %h actual %h", test_name,
                 $sampled(exp_adr), $sampled(wb_adr));
    end

    a_four_beats: assert property (@(posedge clock) disable iff (reset)
        $fell(wb_cyc) |-> beat_no == LINE_WORDS)
    else begin
        error_count = error_count + 1;
        $display("Fail %s: acks per refill expected %0d actual %0d", test_name,
                 LINE_WORDS, $sampled(beat_no));
    end

    a_release: assert property (@(posedge clock) disable iff (reset)
        wb_cyc && wb_ack && beat_no == LINE_WORDS - 1 |=> !wb_cyc && !wb_stb)
    else begin
        error_count = error_count + 1;
        $display("%s: bus not released after the last ack", test_name);
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        int i;
        void'($urandom(32'he1d18505));
        clock       = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        error_count = 0;
        exp_hits    = '0;
        exp_misses  = '0;
        expect_hit  = 1'b0;
        exp_data    = '0;
        test_name   = "reset";
        for (i = 0; i < LINES; i++) begin
            shadow_valid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;

        test_name = "cold_miss";
        issue_request(32'h0000_0124);         // tag 1, line 2, word 1

        test_name = "hit";
        for (i = 0; i < LINE_WORDS; i++) begin
            issue_request(32'h0000_0120 + 4 * i);
        end
        i_wb_mem_model.set_word(32'h0000_0128, 32'h0bad_c0de);
        issue_request(32'h0000_0128);         // stale word still cached

        test_name = "conflict";
        issue_request(32'h0000_0528);         // same line, tag 5
        issue_request(32'h0000_0128);         // evicted, new memory word

        test_name = "flush";
        issue_request(32'h0000_0230);
        issue_request(32'h0000_0230);
        i_wb_mem_model.set_word(32'h0000_0230, 32'h1357_9bdf);
        pulse_flush();
        issue_request(32'h0000_0230);

        test_name = "random";
        for (i = 0; i < NUM_RANDOM; i++) begin
            issue_request(random_addr());
        end
        repeat (2) @(posedge clock);          // last checks sample

        $display("%0d requests, %0d hits, %0d misses, %0d errors", NUM_REQUESTS,
                 exp_hits, exp_misses, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog, bounded by the worst case refill per request
    initial begin
        repeat (RESET_CYCLES + NUM_REQUESTS * CYCLES_PER_REQ) @(posedge clock);
        $display("watchdog expired, the cache stopped answering requests");
        $display("%0d errors before the timeout", error_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_lookup.sv
rtl/icache_refill.sv
rtl/icache_top.sv
tb/wb_mem_model.sv
tb/icache_tb.sv
